/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = lsu_tb
FILELIST = compile.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_ctrl.sv
design/lsu_store_unit.sv
design/lsu_load_unit.sv
design/lsu_data_mem.sv
design/lsu_top.sv
testbench/lsu_checker.sv
testbench/lsu_tb.sv

/* design/lsu_agu.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_agu (
  input  lsu_pkg::lsu_req_t req_i,
  output lsu_pkg::lsu_agu_t agu_o
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] vaddr;
  logic [1:0]           size;
  logic                 is_store;
  logic                 misaligned;

  // --------------------
  // Address generation
  // --------------------

  assign vaddr = $unsigned($signed(req_i.operand_a) + $signed(req_i.imm));

  // Transfer size: 0 byte, 1 half-word, 2 word
  always_comb begin
    size     = 2'd0;
    is_store = 1'b0;
    unique case (req_i.op)
      LB, LBU: size = 2'd0;
      LH, LHU: size = 2'd1;
      LW:      size = 2'd2;
      SB: begin
        size     = 2'd0;
        is_store = 1'b1;
      end
      SH: begin
        size     = 2'd1;
        is_store = 1'b1;
      end
      SW: begin
        size     = 2'd2;
        is_store = 1'b1;
      end
      default: ;
    endcase
  end

  // --------------------
  // Alignment check
  // --------------------

  // Bytes are always aligned
  assign misaligned = ((size == 2'd1) && vaddr[0]) ||
                      ((size == 2'd2) && (vaddr[1:0] != 2'b00));

  always_comb begin
    agu_o.vaddr = vaddr;
    unique case (size)
      2'd0:    agu_o.be = 4'b0001 << vaddr[1:0];
      2'd1:    agu_o.be = 4'b0011 << vaddr[1:0];
      default: agu_o.be = 4'b1111;
    endcase

    agu_o.ex = '0;
    if (misaligned) begin
      agu_o.ex.valid = 1'b1;
      agu_o.ex.cause = is_store ? `LSU_CAUSE_ST_MISALIGNED : `LSU_CAUSE_LD_MISALIGNED;
      agu_o.ex.tval  = vaddr;
    end
  end

endmodule

`default_nettype wire

/* design/lsu_ctrl.sv */
`default_nettype none

module lsu_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  lsu_pkg::lsu_req_t   req_i,
  input  lsu_pkg::lsu_agu_t   agu_i,
  output lsu_pkg::lsu_stage_t stage_o,
  output logic                mem_we_o,
  output logic                mem_re_o,
  output lsu_pkg::lsu_stage_t res_stage_o,
  input  lsu_pkg::lsu_res_t   res_i,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output lsu_pkg::lsu_res_t   res_o
);
  import lsu_pkg::*;

  pipe_state_e state_q;
  pipe_state_e state_d;
  lsu_stage_t  req_q;
  lsu_stage_t  res_q;
  logic        req_full;
  logic        res_full;
  logic        req_full_d;
  logic        res_full_d;
  logic        accept;
  logic        advance;
  logic        req_is_load;
  logic        req_is_store;
  logic        mem_ok;

  // --------------------
  // Stage occupancy
  // --------------------

  assign req_full = (state_q == PIPE_REQ) || (state_q == PIPE_BOTH);
  assign res_full = (state_q == PIPE_RES) || (state_q == PIPE_BOTH);

  // Request moves on when the result slot is free or being emptied
  assign advance     = req_full && (!res_full || res_ready_i);
  assign req_ready_o = !req_full || advance;
  assign accept      = req_valid_i && req_ready_o;

  assign req_full_d = accept || (req_full && !advance);
  assign res_full_d = advance || (res_full && !res_ready_i);

  always_comb begin
    unique case ({res_full_d, req_full_d})
      2'b01:   state_d = PIPE_REQ;
      2'b10:   state_d = PIPE_RES;
      2'b11:   state_d = PIPE_BOTH;
      default: state_d = PIPE_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PIPE_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Stage registers
  // --------------------

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.op         <= req_i.op;
      req_q.trans_id   <= req_i.trans_id;
      req_q.vaddr      <= agu_i.vaddr;
      req_q.be         <= agu_i.be;
      req_q.store_data <= req_i.store_data;
      req_q.ex         <= agu_i.ex;
    end
    if (advance) begin
      res_q <= req_q;
    end
  end

  // --------------------
  // Load/store dispatch
  // --------------------

  always_comb begin
    req_is_load  = 1'b0;
    req_is_store = 1'b0;
    unique case (req_q.op)
      LB, LBU, LH, LHU, LW: req_is_load = 1'b1;
      SB, SH, SW:           req_is_store = 1'b1;
      default: ;
    endcase
  end

  // A faulting request never reaches the scratchpad
  assign mem_ok   = advance && !req_q.ex.valid;
  assign mem_we_o = mem_ok && req_is_store;
  assign mem_re_o = mem_ok && req_is_load;

  assign stage_o     = req_q;
  assign res_stage_o = res_q;
  assign res_valid_o = res_full;
  assign res_o       = res_i;

endmodule

`default_nettype wire

/* design/lsu_data_mem.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_data_mem (
  input  logic                   clk_i,
  input  logic                   we_i,
  input  logic                   re_i,
  input  logic [`LSU_MEM_AW-1:0] addr_i,
  input  logic [`LSU_XLEN-1:0]   wdata_i,
  input  logic [3:0]             wbe_i,
  output logic [`LSU_XLEN-1:0]   rdata_o
);

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

  // --------------------
  // Byte-lane write
  // --------------------

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int i = 0; i < 4; i++) begin
        if (wbe_i[i]) begin
          mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // Read data only changes on a read, so it holds under stall
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

/* design/lsu_load_unit.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_load_unit (
  input  lsu_pkg::lsu_stage_t   stage_i,
  input  logic [`LSU_XLEN-1:0]  rdata_i,
  output lsu_pkg::lsu_res_t     res_o
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] shifted;
  logic                 is_store;

  // Bring the addressed byte or half-word down to lane 0
  assign shifted = rdata_i >> {stage_i.vaddr[1:0], 3'b000};

  assign is_store = (stage_i.op == SB) || (stage_i.op == SH) || (stage_i.op == SW);

  always_comb begin
    res_o.is_store = is_store;
    res_o.trans_id = stage_i.trans_id;
    res_o.ex       = stage_i.ex;
    res_o.data     = '0;

    if (!stage_i.ex.valid) begin
      unique case (stage_i.op)
        LB:  res_o.data = {{24{shifted[7]}}, shifted[7:0]};
        LBU: res_o.data = {24'b0, shifted[7:0]};
        LH:  res_o.data = {{16{shifted[15]}}, shifted[15:0]};
        LHU: res_o.data = {16'b0, shifted[15:0]};
        LW:  res_o.data = rdata_i;
        // Stores return no data
        default: res_o.data = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// --------------------
// Datapath widths
// --------------------

`define LSU_XLEN 32
`define LSU_ID_W 4

// --------------------
// Scratchpad geometry
// --------------------

// 256 words of 4 bytes, so byte address bits 9:2 select the word
`define LSU_MEM_WORDS 256
`define LSU_MEM_AW 8

// --------------------
// Exception causes
// --------------------

`define LSU_CAUSE_LD_MISALIGNED 4'd4
`define LSU_CAUSE_ST_MISALIGNED 4'd6

`endif

/* design/lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  // Memory operations handled by the LSU
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // Occupancy of the request and result stages
  typedef enum logic [1:0] {
    PIPE_EMPTY = 2'b00,
    PIPE_REQ   = 2'b01,
    PIPE_RES   = 2'b10,
    PIPE_BOTH  = 2'b11
  } pipe_state_e;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] operand_a;
    logic [`LSU_XLEN-1:0] imm;
    logic [`LSU_XLEN-1:0] store_data;
    lsu_op_e              op;
    logic [`LSU_ID_W-1:0] trans_id;
  } lsu_req_t;

  typedef struct packed {
    logic                 valid;
    logic [3:0]           cause;
    logic [`LSU_XLEN-1:0] tval;
  } lsu_ex_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] vaddr;
    logic [3:0]           be;
    lsu_ex_t              ex;
  } lsu_agu_t;

  // Request as held in a pipeline stage
  typedef struct packed {
    lsu_op_e              op;
    logic [`LSU_ID_W-1:0] trans_id;
    logic [`LSU_XLEN-1:0] vaddr;
    logic [3:0]           be;
    logic [`LSU_XLEN-1:0] store_data;
    lsu_ex_t              ex;
  } lsu_stage_t;

  typedef struct packed {
    logic                 is_store;
    logic [`LSU_ID_W-1:0] trans_id;
    logic [`LSU_XLEN-1:0] data;
    lsu_ex_t              ex;
  } lsu_res_t;

endpackage

`default_nettype wire

/* design/lsu_store_unit.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_store_unit (
  input  lsu_pkg::lsu_stage_t   stage_i,
  output logic [`LSU_XLEN-1:0]  wdata_o,
  output logic [3:0]            wbe_o
);
  import lsu_pkg::*;

  logic [7:0]  st_byte;
  logic [15:0] st_half;

  assign st_byte = stage_i.store_data[7:0];
  assign st_half = stage_i.store_data[15:0];

  // Copy narrow data to every lane, the byte enables pick the target
  always_comb begin
    unique case (stage_i.op)
      SB:      wdata_o = {4{st_byte}};
      SH:      wdata_o = {2{st_half}};
      default: wdata_o = stage_i.store_data;
    endcase
  end

  assign wbe_o = stage_i.be;

endmodule

`default_nettype wire

/* design/lsu_top.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output lsu_pkg::lsu_res_t res_o
);
  import lsu_pkg::*;

  lsu_agu_t             agu;
  lsu_stage_t           req_stage;
  lsu_stage_t           res_stage;
  lsu_res_t             load_res;
  logic                 mem_we;
  logic                 mem_re;
  logic [`LSU_XLEN-1:0] wdata;
  logic [`LSU_XLEN-1:0] rdata;
  logic [3:0]           wbe;

  lsu_agu i_agu (
    .req_i (req_i),
    .agu_o (agu)
  );

  lsu_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .agu_i       (agu),
    .stage_o     (req_stage),
    .mem_we_o    (mem_we),
    .mem_re_o    (mem_re),
    .res_stage_o (res_stage),
    .res_i       (load_res),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

  lsu_store_unit i_store_unit (
    .stage_i (req_stage),
    .wdata_o (wdata),
    .wbe_o   (wbe)
  );

  // Word address from byte address bits 9:2, higher bits alias
  lsu_data_mem i_data_mem (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .re_i    (mem_re),
    .addr_i  (req_stage.vaddr[`LSU_MEM_AW+1:2]),
    .wdata_i (wdata),
    .wbe_i   (wbe),
    .rdata_o (rdata)
  );

  lsu_load_unit i_load_unit (
    .stage_i (res_stage),
    .rdata_i (rdata),
    .res_o   (load_res)
  );

endmodule

`default_nettype wire

/* testbench/lsu_checker.sv */
`default_nettype none

module lsu_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_valid_i,
  input logic              req_ready_i,
  input logic              res_valid_i,
  input logic              res_ready_i,
  input lsu_pkg::lsu_res_t res_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of assertion failures so far
  int fail_cnt = 0;

  // A result on offer holds until it is taken
  res_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else begin
      $error("Result changed or dropped while stalled");
      fail_cnt++;
    end

  // Nothing leaves the LSU while reset is applied
  res_in_reset: assert property (@(posedge clk_i) !rst_ni |=> !res_valid_i)
    else begin
      $error("Result valid during reset");
      fail_cnt++;
    end

  // Accept on one edge and a free result slot on the next give a result after that
  res_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(req_valid_i && req_ready_i) && res_ready_i |=> res_valid_i)
    else begin
      $error("No result two cycles after accept");
      fail_cnt++;
    end

endmodule

bind lsu_top lsu_checker checker_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .res_valid_i (res_valid_o),
  .res_ready_i (res_ready_i),
  .res_i       (res_o)
);

`default_nettype wire

/* testbench/lsu_tb.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  // One table row with its expected result
  typedef struct packed {
    lsu_op_e              op;
    logic [`LSU_XLEN-1:0] a;
    logic [`LSU_XLEN-1:0] imm;
    logic [`LSU_XLEN-1:0] wdata;
    logic                 is_store;
    logic [`LSU_XLEN-1:0] data;
    logic                 ex;
    logic [3:0]           cause;
  } test_t;

  localparam int         PASSES = 2;
  localparam logic [3:0] LD_MIS = 4'd4;
  localparam logic [3:0] ST_MIS = 4'd6;

  logic     clk_i;
  logic     rst_ni;
  logic     req_valid_i;
  logic     req_ready_o;
  lsu_req_t req_i;
  logic     res_valid_o;
  logic     res_ready_i;
  lsu_res_t res_o;

  test_t       tests[$];
  int          acc_q[$];
  int          cycle_cnt = 0;
  int          received = 0;
  int          data_errs = 0;
  int          tag_errs = 0;
  int          ex_errs = 0;
  int          flow_errs = 0;
  int          assert_errs = 0;
  logic [31:0] lfsr = 32'h3bd4;
  logic        bp_en = 1'b0;

  lsu_top dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

  // --------------------
  // Clock and timeout
  // --------------------

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  always @(negedge clk_i) begin
    if (cycle_cnt > 4 * PASSES * tests.size() + 100) begin
      $display("Timeout with %0d results after %0d cycles", received, cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  // Stall roughly one result cycle in four once enabled
  initial begin
    logic b0;
    logic b1;
    res_ready_i <= 1'b1;
    forever begin
      @(posedge clk_i);
      if (bp_en) begin
        take_bit(b0);
        take_bit(b1);
        res_ready_i <= !(b0 && b1);
      end else begin
        res_ready_i <= 1'b1;
      end
    end
  end

  // --------------------
  // Table and checks
  // --------------------

  function automatic void add_test(input lsu_op_e op, input logic [31:0] a, input logic [31:0] imm,
                                   input logic [31:0] wdata, input logic st,
                                   input logic [31:0] data, input logic ex, input logic [3:0] cause);
    tests.push_back('{op, a, imm, wdata, st, data, ex, cause});
  endfunction

  function automatic void load_table();
    add_test(SW,  32'h100, 32'h0, 32'h1234_5678, 1'b1, 32'h0, 1'b0, 4'd0);
    // Bits above 9 are ignored, so both reach the word just written
    add_test(LW,  32'h500, 32'h0, 32'h0, 1'b0, 32'h1234_5678, 1'b0, 4'd0);
    add_test(LW,  32'hffff_fd04, 32'hffff_fffc, 32'h0, 1'b0, 32'h1234_5678, 1'b0, 4'd0);
    add_test(SW,  32'h40, 32'h0, 32'haabb_ccdd, 1'b1, 32'h0, 1'b0, 4'd0);
    add_test(SB,  32'h40, 32'h1, 32'h11, 1'b1, 32'h0, 1'b0, 4'd0);
    add_test(SH,  32'h40, 32'h2, 32'h2233, 1'b1, 32'h0, 1'b0, 4'd0);
    add_test(LW,  32'h40, 32'h0, 32'h0, 1'b0, 32'h2233_11dd, 1'b0, 4'd0);
    add_test(SW,  32'h80, 32'h0, 32'h80f1_7f01, 1'b1, 32'h0, 1'b0, 4'd0);
    add_test(LB,  32'h80, 32'h0, 32'h0, 1'b0, 32'h0000_0001, 1'b0, 4'd0);
    add_test(LB,  32'h80, 32'h1, 32'h0, 1'b0, 32'h0000_007f, 1'b0, 4'd0);
    add_test(LB,  32'h80, 32'h2, 32'h0, 1'b0, 32'hffff_fff1, 1'b0, 4'd0);
    add_test(LB,  32'h80, 32'h3, 32'h0, 1'b0, 32'hffff_ff80, 1'b0, 4'd0);
    add_test(LBU, 32'h80, 32'h2, 32'h0, 1'b0, 32'h0000_00f1, 1'b0, 4'd0);
    add_test(LH,  32'h80, 32'h2, 32'h0, 1'b0, 32'hffff_80f1, 1'b0, 4'd0);
    add_test(LHU, 32'h80, 32'h0, 32'h0, 1'b0, 32'h0000_7f01, 1'b0, 4'd0);
    add_test(LHU, 32'h80, 32'h2, 32'h0, 1'b0, 32'h0000_80f1, 1'b0, 4'd0);
    add_test(LBU, 32'h80, 32'h0, 32'h0, 1'b0, 32'h0000_0001, 1'b0, 4'd0);
    add_test(LBU, 32'h80, 32'h1, 32'h0, 1'b0, 32'h0000_007f, 1'b0, 4'd0);
    add_test(LBU, 32'h80, 32'h3, 32'h0, 1'b0, 32'h0000_0080, 1'b0, 4'd0);
    add_test(LH,  32'h80, 32'h0, 32'h0, 1'b0, 32'h0000_7f01, 1'b0, 4'd0);
    // Misaligned accesses, the stores must not reach memory
    add_test(LH,  32'h81, 32'h0, 32'h0, 1'b0, 32'h0, 1'b1, LD_MIS);
    add_test(LW,  32'h80, 32'h2, 32'h0, 1'b0, 32'h0, 1'b1, LD_MIS);
    add_test(SH,  32'h80, 32'h3, 32'hffff, 1'b1, 32'h0, 1'b1, ST_MIS);
    add_test(SW,  32'h81, 32'h0, 32'hdead_beef, 1'b1, 32'h0, 1'b1, ST_MIS);
    add_test(LW,  32'h80, 32'h0, 32'h0, 1'b0, 32'h80f1_7f01, 1'b0, 4'd0);
  endfunction

  function automatic lsu_res_t expect_res(input test_t t, input logic [`LSU_ID_W-1:0] id);
    lsu_res_t r;
    r.is_store = t.is_store;
    r.trans_id = id;
    r.data     = t.data;
    r.ex       = '0;
    if (t.ex) begin
      r.ex.valid = 1'b1;
      r.ex.cause = t.cause;
      r.ex.tval  = t.a + t.imm;
    end
    return r;
  endfunction

  task automatic compare_load(input string name, input lsu_res_t exp, input lsu_res_t act);
    if (act.data !== exp.data) begin
      $display("** Error %s data expected %h actual %h", name, exp.data, act.data);
      data_errs++;
    end
    if (act.trans_id !== exp.trans_id) begin
      $display("** Error %s trans_id expected %0d actual %0d", name, exp.trans_id, act.trans_id);
      tag_errs++;
    end
    if (act.is_store !== exp.is_store) begin
      $display("** Error %s is_store expected %0b actual %0b", name, exp.is_store, act.is_store);
      tag_errs++;
    end
  endtask

  task automatic compare_store(input string name, input lsu_res_t exp, input lsu_res_t act);
    if (act.trans_id !== exp.trans_id || act.is_store !== exp.is_store) begin
      $display("** Error %s trans_id/is_store expected %0d/%0b actual %0d/%0b", name,
               exp.trans_id, exp.is_store, act.trans_id, act.is_store);
      tag_errs++;
    end
    if (act.data !== exp.data) begin
      $display("** Error %s data expected %h actual %h", name, exp.data, act.data);
      data_errs++;
    end
  endtask

  task automatic compare_ex(input string name, input lsu_ex_t exp, input lsu_ex_t act);
    if (act !== exp) begin
      $display("** Error %s exception expected %0b/%0d/%h actual %0b/%0d/%h", name,
               exp.valid, exp.cause, exp.tval, act.valid, act.cause, act.tval);
      ex_errs++;
    end
  endtask

  // Holds the request until the DUT takes it on a rising edge
  task automatic send_req(input test_t t, input logic [`LSU_ID_W-1:0] id);
    logic taken;
    taken = 1'b0;
    req_valid_i <= 1'b1;
    req_i       <= '{t.a, t.imm, t.wdata, t.op, id};
    while (!taken) begin
      @(negedge clk_i);
      taken = req_ready_o;
      if (taken) acc_q.push_back(cycle_cnt);
      @(posedge clk_i);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int seq;
    seq = 0;
    rst_ni      <= 1'b0;
    req_valid_i <= 1'b0;
    req_i       <= '0;
    load_table();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    fork
      begin
        for (int p = 0; p < PASSES; p++) begin
          for (int i = 0; i < tests.size(); i++) begin
            send_req(tests[i], seq[`LSU_ID_W-1:0]);
            seq++;
          end
          req_valid_i <= 1'b0;
          wait (received == (p + 1) * tests.size());
          // Later passes see random result back-pressure
          bp_en = 1'b1;
          @(posedge clk_i);
        end
      end
      begin
        int       idx;
        int       lat;
        int       prev;
        lsu_op_e  op;
        lsu_res_t exp;
        lsu_res_t act;
        string    name;
        prev = 0;
        while (received < PASSES * tests.size()) begin
          @(negedge clk_i);
          if (res_valid_o && res_ready_i) begin
            idx  = received % tests.size();
            op   = tests[idx].op;
            act  = res_o;
            exp  = expect_res(tests[idx], received[`LSU_ID_W-1:0]);
            name = $sformatf("pass %0d entry %0d %s", received / tests.size(), idx, op.name());
            lat  = cycle_cnt - acc_q.pop_front();
            if (exp.is_store) compare_store(name, exp, act);
            else compare_load(name, exp, act);
            compare_ex(name, exp.ex, act.ex);
            // First pass runs without stalls, one result per cycle
            if (received < tests.size()) begin
              if (lat != 2) begin
                $display("** Error %s latency expected 2 actual %0d", name, lat);
                flow_errs++;
              end
              if (received > 0 && cycle_cnt != prev + 1) begin
                $display("** Error %s result cycle expected %0d actual %0d", name, prev + 1,
                         cycle_cnt);
                flow_errs++;
              end
            end
            prev = cycle_cnt;
            received++;
          end
        end
      end
    join

    assert_errs = dut_i.checker_i.fail_cnt;
    $display("Errors data %0d id %0d exception %0d timing %0d assertion %0d", data_errs,
             tag_errs, ex_errs, flow_errs, assert_errs);
    if (data_errs + tag_errs + ex_errs + flow_errs + assert_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
